// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // basic widths
    localparam int ADDR_BITS = 32;
    localparam int INST_BITS = 32;

    // 8-byte block, two words per block
    localparam int BLOCK_OFF_BITS = 3;
    localparam int WORDS_PER_BLOCK = 2;
    localparam int BLK_ADDR_BITS = ADDR_BITS - BLOCK_OFF_BITS;

    // direct-mapped icache geometry
    localparam int ICACHE_LINES = 32;
    localparam int ICACHE_IDX_BITS = $clog2(ICACHE_LINES);
    localparam int ICACHE_TAG_BITS = BLK_ADDR_BITS - ICACHE_IDX_BITS;

    // memory tags 1..15, tag 0 reserved for "none"
    localparam int NUM_MEM_TAGS = 15;
    localparam int MEM_TAG_BITS = $clog2(NUM_MEM_TAGS + 1);

    // fetch bandwidth
    localparam int FETCH_WIDTH = 4;
    localparam int FETCH_CNT_BITS = $clog2(FETCH_WIDTH + 1);

    // target block plus the one after it
    localparam int PREFETCH_DISTANCE = 2;

    // instruction buffer space reported by the back end
    localparam int IBUFF_DEPTH = 8;
    localparam int IBUFF_OPEN_BITS = $clog2(IBUFF_DEPTH + 1);

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [INST_BITS-1:0] inst_t;

    // word 0 sits at the lower address
    typedef inst_t [WORDS_PER_BLOCK-1:0] mem_block_t;

    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    // address with the block offset stripped
    typedef logic [BLK_ADDR_BITS-1:0] blk_addr_t;

    typedef logic [ICACHE_IDX_BITS-1:0] icache_idx_t;
    typedef logic [ICACHE_TAG_BITS-1:0] icache_tag_t;

    // branch task from the back end, only squash touches fetch state
    typedef enum logic [1:0] {
        br_none   = 2'd0,
        br_clear  = 2'd1,
        br_squash = 2'd2
    } br_task_t;

endpackage

`default_nettype wire

// ==== source/icache.sv ====
`default_nettype none

module icache
    import fetch_pkg::*;
(
    input  wire logic                         clock,
    input  wire logic                         rst_n,

    // fetch target, looked up together with the next block
    input  wire addr_t                        target,

    // fill port from the miss table
    input  wire logic                         fill_en,
    input  wire addr_t                        fill_addr,
    input  wire mem_block_t                   fill_data,

    // one hit bit and one block per lookup
    output logic       [PREFETCH_DISTANCE-1:0] hit_valid,
    output mem_block_t [PREFETCH_DISTANCE-1:0] hit_data
);

    // line storage
    mem_block_t data_mem [ICACHE_LINES];
    icache_tag_t tag_mem [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] valid_q;

    // fill address split
    blk_addr_t   fill_blk;
    icache_idx_t fill_idx;
    icache_tag_t fill_tag;

    assign fill_blk = fill_addr[ADDR_BITS-1:BLOCK_OFF_BITS];
    assign fill_idx = fill_blk[ICACHE_IDX_BITS-1:0];
    assign fill_tag = fill_blk[BLK_ADDR_BITS-1:ICACHE_IDX_BITS];

    // parallel lookups, block i is target block + i
    for (genvar i = 0; i < PREFETCH_DISTANCE; i++) begin : g_lookup
        blk_addr_t   look_blk;
        icache_idx_t look_idx;
        icache_tag_t look_tag;

        assign look_blk = target[ADDR_BITS-1:BLOCK_OFF_BITS] + blk_addr_t'(i);
        assign look_idx = look_blk[ICACHE_IDX_BITS-1:0];
        assign look_tag = look_blk[BLK_ADDR_BITS-1:ICACHE_IDX_BITS];

        // hit needs valid line and matching tag
        assign hit_valid[i] = valid_q[look_idx] && (tag_mem[look_idx] == look_tag);
        assign hit_data[i]  = data_mem[look_idx];
    end

    // data and tag write on fill
    // no bypass, new block shows up the cycle after the edge
    always_ff @(posedge clock) begin
        if (fill_en) begin
            data_mem[fill_idx] <= fill_data;
            tag_mem[fill_idx]  <= fill_tag;
        end
    end

    // valid bits
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_en) begin
            // overwrite whatever the line held
            valid_q[fill_idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_mshr.sv ====
`default_nettype none

module fetch_mshr
    import fetch_pkg::*;
(
    input  wire logic                         clock,
    input  wire logic                         rst_n,

    input  wire addr_t                        target,
    input  wire br_task_t                     br_task,

    // memory side
    input  wire logic                         arbiter_grant,
    input  wire mem_tag_t                     mem_transaction_tag,
    input  wire mem_tag_t                     mem_data_tag,
    input  wire mem_block_t                   mem_data,

    // icache hit status for target block and next block
    input  wire logic [PREFETCH_DISTANCE-1:0] hit_valid,

    output logic                              mem_en,
    output addr_t                             mem_addr,

    // fill into icache
    output logic                              fill_en,
    output addr_t                             fill_addr,
    output mem_block_t                        fill_data
);

    // table indexed by memory tag, tag 0 never used
    blk_addr_t mshr_blk [1:NUM_MEM_TAGS];
    logic [NUM_MEM_TAGS:1] mshr_valid;

    // low in the first cycle out of reset
    logic run_q;

    logic squash;
    logic resp_ok;
    logic has_free;
    logic accept;
    logic req_need;
    blk_addr_t base_blk;
    blk_addr_t req_blk;
    logic [PREFETCH_DISTANCE-1:0] in_flight;

    assign squash   = (br_task == br_squash);
    assign base_blk = target[ADDR_BITS-1:BLOCK_OFF_BITS];
    assign has_free = ~&mshr_valid;

    // response only counts if its tag is still live
    assign resp_ok   = (mem_data_tag != '0) && mshr_valid[mem_data_tag];
    // a squash in the same cycle drops the response too
    assign fill_en   = resp_ok && !squash;
    assign fill_addr = {mshr_blk[mem_data_tag], {BLOCK_OFF_BITS{1'b0}}};
    assign fill_data = mem_data;

    // is each lookup block already outstanding
    always_comb begin
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            in_flight[i] = 1'b0;
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                if (mshr_valid[t] && (mshr_blk[t] == base_blk + blk_addr_t'(i))) begin
                    in_flight[i] = 1'b1;
                end
            end
        end
    end

    // first block that is neither cached nor in flight
    // walk backwards so the lowest index wins
    always_comb begin
        req_need = 1'b0;
        req_blk  = base_blk;
        for (int i = PREFETCH_DISTANCE - 1; i >= 0; i--) begin
            if (!hit_valid[i] && !in_flight[i]) begin
                req_need = 1'b1;
                req_blk  = base_blk + blk_addr_t'(i);
            end
        end
    end

    // one request per cycle, block-aligned
    assign mem_en   = run_q && arbiter_grant && has_free && req_need && !squash;
    assign mem_addr = {req_blk, {BLOCK_OFF_BITS{1'b0}}};

    // nonzero tag means memory took it
    assign accept = mem_en && (mem_transaction_tag != '0);

    // valid bits and run flag
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mshr_valid <= '0;
            run_q      <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (squash) begin
                mshr_valid <= '0;
            end else begin
                // free first, allocation wins on a tag reuse
                if (resp_ok) begin
                    mshr_valid[mem_data_tag] <= 1'b0;
                end
                if (accept) begin
                    mshr_valid[mem_transaction_tag] <= 1'b1;
                end
            end
        end
    end

    // block address per tag
    always_ff @(posedge clock) begin
        if (accept) begin
            mshr_blk[mem_transaction_tag] <= req_blk;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_packer.sv ====
`default_nettype none

module fetch_packer
    import fetch_pkg::*;
(
    input  wire logic                            clock,
    input  wire logic                            rst_n,

    input  wire addr_t                           target,
    input  wire br_task_t                        br_task,
    input  wire logic       [IBUFF_OPEN_BITS-1:0] ibuff_open,

    // from icache
    input  wire logic       [PREFETCH_DISTANCE-1:0] hit_valid,
    input  wire mem_block_t [PREFETCH_DISTANCE-1:0] hit_data,

    // registered bundle
    output inst_t           [FETCH_WIDTH-1:0]    out_inst,
    output addr_t           [FETCH_WIDTH-1:0]    out_pc,
    output logic            [FETCH_CNT_BITS-1:0] out_num_insts
);

    logic squash;
    logic chain;
    logic [IBUFF_OPEN_BITS-1:0] avail;
    logic [IBUFF_OPEN_BITS-1:0] lim;
    logic [FETCH_CNT_BITS-1:0] count;
    logic [1:0] word_pos;
    inst_t [FETCH_WIDTH-1:0] next_inst;
    addr_t [FETCH_WIDTH-1:0] next_pc;

    assign squash = (br_task == br_squash);

    // consecutive hit words from target, stop at first miss
    always_comb begin
        avail = '0;
        chain = 1'b1;
        for (int b = 0; b < PREFETCH_DISTANCE; b++) begin
            if (chain && hit_valid[b]) begin
                // odd start word leaves one word in the first block
                avail = avail + ((b == 0 && target[2]) ? IBUFF_OPEN_BITS'(1) :
                                                         IBUFF_OPEN_BITS'(2));
            end else begin
                chain = 1'b0;
            end
        end
    end

    // clamp by buffer space and fetch width
    always_comb begin
        lim = avail;
        if (ibuff_open < lim) lim = ibuff_open;
        if (IBUFF_OPEN_BITS'(FETCH_WIDTH) < lim) lim = IBUFF_OPEN_BITS'(FETCH_WIDTH);
        count = lim[FETCH_CNT_BITS-1:0];
    end

    // word select per slot, unused slots stay zero
    always_comb begin
        word_pos = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            next_pc[i]   = '0;
            next_inst[i] = '0;
            if (i < count) begin
                // word offset from target block start, bit 1 picks the block
                word_pos     = 2'(i) + {1'b0, target[2]};
                next_pc[i]   = target + addr_t'(4 * i);
                next_inst[i] = hit_data[word_pos[1]][word_pos[0]];
            end
        end
    end

    // bundle register, emptied by squash
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_inst      <= '0;
            out_pc        <= '0;
            out_num_insts <= '0;
        end else if (squash) begin
            out_inst      <= '0;
            out_pc        <= '0;
            out_num_insts <= '0;
        end else begin
            out_inst      <= next_inst;
            out_pc        <= next_pc;
            out_num_insts <= count;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`default_nettype none

module fetch_stage
    import fetch_pkg::*;
(
    input  wire logic                            clock,
    input  wire logic                            rst_n,

    // front end
    input  wire addr_t                           target,
    input  wire br_task_t                        br_task,
    input  wire logic                            arbiter_grant,
    input  wire logic       [IBUFF_OPEN_BITS-1:0] ibuff_open,

    // tagged memory port
    input  wire mem_tag_t                        mem_transaction_tag,
    input  wire mem_tag_t                        mem_data_tag,
    input  wire mem_block_t                      mem_data,
    output logic                                 mem_en,
    output addr_t                                mem_addr,

    // bundle to the instruction buffer
    output inst_t           [FETCH_WIDTH-1:0]    out_inst,
    output addr_t           [FETCH_WIDTH-1:0]    out_pc,
    output logic            [FETCH_CNT_BITS-1:0] out_num_insts
);

    // fill path, mshr to cache
    logic       fill_en;
    addr_t      fill_addr;
    mem_block_t fill_data;

    // lookup results shared by mshr and packer
    logic       [PREFETCH_DISTANCE-1:0] hit_valid;
    mem_block_t [PREFETCH_DISTANCE-1:0] hit_data;

    icache icache0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .target    (target),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .hit_valid (hit_valid),
        .hit_data  (hit_data)
    );

    // miss handling and memory requests
    fetch_mshr mshr0 (
        .clock               (clock),
        .rst_n               (rst_n),
        .target              (target),
        .br_task             (br_task),
        .arbiter_grant       (arbiter_grant),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .hit_valid           (hit_valid),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .fill_en             (fill_en),
        .fill_addr           (fill_addr),
        .fill_data           (fill_data)
    );

    fetch_packer packer0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .target        (target),
        .br_task       (br_task),
        .ibuff_open    (ibuff_open),
        .hit_valid     (hit_valid),
        .hit_data      (hit_data),
        .out_inst      (out_inst),
        .out_pc        (out_pc),
        .out_num_insts (out_num_insts)
    );

endmodule

`default_nettype wire

// ==== testbench/fetch_stage_sva.sv ====
`default_nettype none

module fetch_stage_sva
    import fetch_pkg::*;
(
    input wire logic                      clock,
    input wire logic                      rst_n,
    input wire logic                      mem_en,
    input wire addr_t                     mem_addr,
    input wire logic [FETCH_CNT_BITS-1:0] out_num_insts
);

    timeunit 1ns;
    timeprecision 1ps;

    // no memory traffic while reset is held
    mem_en_in_reset: assert property (@(posedge clock) !rst_n |-> !mem_en)
        else $error("mem_en high during reset");

    // requests cover whole blocks
    mem_addr_aligned: assert property (
        @(posedge clock) disable iff (!rst_n)
        mem_en |-> (mem_addr[BLOCK_OFF_BITS-1:0] == '0)
    ) else $error("mem_addr 0x%0h not block aligned", mem_addr);

    // bundle never wider than the fetch width
    bundle_width: assert property (
        @(posedge clock) disable iff (!rst_n)
        out_num_insts <= FETCH_CNT_BITS'(FETCH_WIDTH)
    ) else $error("out_num_insts %0d above fetch width", out_num_insts);

endmodule

bind fetch_stage fetch_stage_sva sva0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .mem_en        (mem_en),
    .mem_addr      (mem_addr),
    .out_num_insts (out_num_insts)
);

`default_nettype wire

// ==== testbench/fetch_stage_tb.sv ====
`default_nettype none

module fetch_stage_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 4000;
    localparam int SEED         = 21644;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD + 1000;
    // every memory word is its byte address xor this key
    localparam inst_t INST_KEY  = 32'h5a3c_96e1;
    // window is twice the cache, so lines get evicted
    localparam addr_t WIN_BASE  = 32'h0000_1000;
    localparam int    WIN_BYTES = 512;

    logic clock;
    logic rst_n;
    addr_t target;
    br_task_t br_task;
    logic arbiter_grant;
    logic [IBUFF_OPEN_BITS-1:0] ibuff_open;
    mem_tag_t mem_transaction_tag;
    mem_tag_t mem_data_tag;
    mem_block_t mem_data;
    logic mem_en;
    addr_t mem_addr;
    inst_t [FETCH_WIDTH-1:0] out_inst;
    addr_t [FETCH_WIDTH-1:0] out_pc;
    logic [FETCH_CNT_BITS-1:0] out_num_insts;

    // model of the miss table and the cache lines
    logic [NUM_MEM_TAGS:1] model_valid;
    blk_addr_t model_blk [1:NUM_MEM_TAGS];
    logic [ICACHE_LINES-1:0] line_valid;
    blk_addr_t line_blk [ICACHE_LINES];
    logic run_seen;
    // bundle due in the next cycle
    logic [FETCH_CNT_BITS-1:0] exp_cnt;
    addr_t exp_target;
    // request taken by memory this cycle
    logic acc_now;
    mem_tag_t acc_tag;
    addr_t acc_addr;
    // memory side bookkeeping
    logic [NUM_MEM_TAGS:1] mem_busy;
    blk_addr_t mem_blk [1:NUM_MEM_TAGS];
    int mem_delay [1:NUM_MEM_TAGS];
    mem_tag_t resp_tag;
    int tgt_off;
    int err_count;

    fetch_stage dut0 (
        .clock               (clock),
        .rst_n               (rst_n),
        .target              (target),
        .br_task             (br_task),
        .arbiter_grant       (arbiter_grant),
        .ibuff_open          (ibuff_open),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .out_inst            (out_inst),
        .out_pc              (out_pc),
        .out_num_insts       (out_num_insts)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] time %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic line_hit(input blk_addr_t blk);
        icache_idx_t idx;
        idx = blk[ICACHE_IDX_BITS-1:0];
        return line_valid[idx] && (line_blk[idx] == blk);
    endfunction

    task automatic reset_model();
        model_valid = '0;
        line_valid  = '0;
        run_seen    = 1'b0;
        exp_cnt     = '0;
        exp_target  = '0;
        acc_now     = 1'b0;
        acc_tag     = '0;
        acc_addr    = '0;
    endtask

    // registered bundle against last cycle's prediction
    task automatic check_bundle();
        addr_t pc;
        check_value("out_num_insts", 64'(out_num_insts), 64'(exp_cnt));
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pc = (i < int'(exp_cnt)) ? exp_target + addr_t'(4 * i) : '0;
            check_value($sformatf("out_pc[%0d]", i), 64'(out_pc[i]), 64'(pc));
            if (i < int'(exp_cnt)) begin
                pc = pc ^ INST_KEY;
            end
            check_value($sformatf("out_inst[%0d]", i), 64'(out_inst[i]), 64'(pc));
        end
    endtask

    // first block of the pair that is neither cached nor outstanding
    task automatic check_request();
        blk_addr_t blk;
        logic need;
        logic busy;
        logic exp_en;
        addr_t exp_addr;
        int used;
        need     = 1'b0;
        exp_addr = '0;
        used     = 0;
        for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
            used += int'(model_valid[t]);
        end
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            blk  = target[ADDR_BITS-1:BLOCK_OFF_BITS] + blk_addr_t'(i);
            busy = 1'b0;
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                busy |= model_valid[t] && (model_blk[t] == blk);
            end
            if (!need && !busy && !line_hit(blk)) begin
                need     = 1'b1;
                exp_addr = {blk, {BLOCK_OFF_BITS{1'b0}}};
            end
        end
        // quiet for one cycle after reset release
        exp_en = run_seen && arbiter_grant && (used < NUM_MEM_TAGS) && need &&
                 (br_task != br_squash);
        check_value("mem_en", 64'(mem_en), 64'(exp_en));
        if (exp_en) begin
            check_value("mem_addr", 64'(mem_addr), 64'(exp_addr));
        end
        acc_now  = exp_en && (mem_transaction_tag != '0);
        acc_tag  = mem_transaction_tag;
        acc_addr = exp_addr;
    endtask

    task automatic predict_bundle();
        blk_addr_t base;
        int cnt;
        base = target[ADDR_BITS-1:BLOCK_OFF_BITS];
        cnt  = 0;
        if (line_hit(base)) begin
            // odd start word gives one word from the first block
            cnt = target[2] ? 1 : 2;
            if (line_hit(base + blk_addr_t'(1))) begin
                cnt += 2;
            end
        end
        cnt = (int'(ibuff_open) < cnt) ? int'(ibuff_open) : cnt;
        cnt = (FETCH_WIDTH < cnt) ? FETCH_WIDTH : cnt;
        exp_cnt    = (br_task == br_squash) ? '0 : FETCH_CNT_BITS'(cnt);
        exp_target = target;
    endtask

    // state after the coming edge, responses to dead tags are dropped
    task automatic update_model();
        blk_addr_t blk;
        if (br_task == br_squash) begin
            model_valid = '0;
        end else begin
            if (mem_data_tag != '0 && model_valid[mem_data_tag]) begin
                blk = model_blk[mem_data_tag];
                line_valid[blk[ICACHE_IDX_BITS-1:0]] = 1'b1;
                line_blk[blk[ICACHE_IDX_BITS-1:0]]   = blk;
                model_valid[mem_data_tag] = 1'b0;
            end
            if (acc_now) begin
                model_valid[acc_tag] = 1'b1;
                model_blk[acc_tag]   = acc_addr[ADDR_BITS-1:BLOCK_OFF_BITS];
            end
        end
    endtask

    // tagged memory, one response per cycle, tags held until answered
    task automatic drive_memory();
        int start;
        int t;
        logic offer;
        mem_tag_t pick;
        addr_t base;
        mem_block_t data;
        pick = '0;
        if (!rst_n) begin
            mem_busy = '0;
            resp_tag = '0;
        end else begin
            if (resp_tag != '0) begin
                mem_busy[resp_tag] = 1'b0;
            end
            resp_tag = '0;
            if (acc_now) begin
                mem_busy[acc_tag]  = 1'b1;
                mem_blk[acc_tag]   = acc_addr[ADDR_BITS-1:BLOCK_OFF_BITS];
                mem_delay[acc_tag] = 1 + int'($urandom % 12);
            end
            for (t = 1; t <= NUM_MEM_TAGS; t++) begin
                if (mem_busy[t] && mem_delay[t] > 0) begin
                    mem_delay[t]--;
                end
                if (mem_busy[t] && mem_delay[t] == 0 && resp_tag == '0) begin
                    resp_tag = mem_tag_t'(t);
                end
            end
            // a free tag three cycles out of four
            start = int'($urandom % NUM_MEM_TAGS);
            offer = ($urandom % 4) != 0;
            for (int k = 0; k < NUM_MEM_TAGS; k++) begin
                t = 1 + (start + k) % NUM_MEM_TAGS;
                if (offer && !mem_busy[t] && pick == '0) begin
                    pick = mem_tag_t'(t);
                end
            end
        end
        base    = (resp_tag != '0) ? {mem_blk[resp_tag], {BLOCK_OFF_BITS{1'b0}}} : '0;
        data[0] = (resp_tag != '0) ? base ^ INST_KEY : '0;
        data[1] = (resp_tag != '0) ? (base + addr_t'(4)) ^ INST_KEY : '0;
        mem_data_tag        <= resp_tag;
        mem_data            <= data;
        mem_transaction_tag <= pick;
    endtask

    // target mostly holds or steps, sometimes jumps
    task automatic drive_front_end();
        int r;
        r = int'($urandom % 20);
        br_task       <= (r == 0) ? br_squash : ((r == 1) ? br_clear : br_none);
        ibuff_open    <= IBUFF_OPEN_BITS'($urandom % (IBUFF_DEPTH + 1));
        arbiter_grant <= ($urandom % 4) != 0;
        r = int'($urandom % 16);
        if (r == 0) begin
            tgt_off = int'($urandom % WIN_BYTES);
        end else begin
            tgt_off = tgt_off + ((r % 4 < 2) ? 0 : 4 * (r % 4 - 1));
        end
        tgt_off = (tgt_off % WIN_BYTES) & ~3;
        target <= WIN_BASE + addr_t'(tgt_off);
    endtask

    always @(negedge clock) begin
        check_bundle();
        if (!rst_n) begin
            check_value("mem_en", 64'(mem_en), 64'd0);
            reset_model();
        end else begin
            check_request();
            predict_bundle();
            update_model();
            run_seen = 1'b1;
        end
    end

    initial begin
        int unsigned seed;
        clock = 1'b0;
        rst_n = 1'b0;
        target = WIN_BASE;
        br_task = br_none;
        // grant up through reset, the stage must still stay quiet
        arbiter_grant = 1'b1;
        ibuff_open = '0;
        mem_transaction_tag = '0;
        mem_data_tag = '0;
        mem_data = '0;
        mem_busy = '0;
        resp_tag = '0;
        tgt_off = 0;
        err_count = 0;
        reset_model();
        seed = $urandom(SEED);
        for (int cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++) begin
            @(posedge clock);
            if (cyc == RESET_CYCLES) begin
                rst_n <= 1'b1;
            end
            if (cyc > RESET_CYCLES) begin
                drive_front_end();
            end
            drive_memory();
        end
        // let the last negedge checks run
        repeat (2) @(posedge clock);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not end within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== fetch_stage.f ====
source/fetch_pkg.sv
source/icache.sv
source/fetch_mshr.sv
source/fetch_packer.sv
source/fetch_stage.sv
testbench/fetch_stage_sva.sv
testbench/fetch_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
BUILD_LOG="$BUILD_DIR/build.log"
SIM_LOG="$BUILD_DIR/sim.log"

if ! mkdir -p "$BUILD_DIR"; then
    echo "cannot create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module fetch_stage_tb \
    -Mdir "$BUILD_DIR/obj_dir" \
    -f fetch_stage.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

"$BUILD_DIR/obj_dir/Vfetch_stage_tb" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Test failed" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "FAIL: simulation exited with status $sim_status"
    exit 1
fi
echo "PASS"
exit 0
